// File: logic/rv_pkg.sv
package rv_pkg;

  // ========================================
  // widths
  // ========================================
  localparam int XLEN       = 32;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int SHAMT_W    = 5;

  // ========================================
  // fetch constants
  // ========================================
  localparam logic [XLEN-1:0] RESET_PC = '0;
  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

  // addi x0, x0, 0
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  // ========================================
  // funct3 codes
  // ========================================
  // alu group, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // branch group
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // ========================================
  // enums
  // ========================================
  // major opcodes kept by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // lui result is the immediate itself
    ALU_PASS_B
  } alu_op_e;

endpackage

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            equal_o
);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  // shifts only look at the low five bits
  assign shamt = b_i[SHAMT_W-1:0];

  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

  // branch compare
  assign equal_o = (a_i == b_i);

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [REG_ADDR_W-1:0] raddr1_i,
  input  logic [REG_ADDR_W-1:0] raddr2_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic                  we_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // x0 never written
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-through so the same-cycle reader sees write-back data
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    logic [XLEN-1:0] value;
    if (we_i && (waddr_i != '0) && (waddr_i == addr)) begin
      value = wdata_i;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  assign rdata1_o = read_port(raddr1_i);
  assign rdata2_o = read_port(raddr2_i);

  // entry zero is cleared on reset and skipped by writes and the bypass
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (raddr1_i == '0) |-> (rdata1_o == '0))
    else $error("x0 read on port 1 returned nonzero");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    (raddr2_i == '0) |-> (rdata2_o == '0))
    else $error("x0 read on port 2 returned nonzero");

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              redirect_i,
  input  logic [XLEN-1:0]   redirect_pc_i,
  input  logic [INST_W-1:0] imem_data_i,
  output logic [XLEN-1:0]   imem_addr_o,
  output logic              fetch_valid_o,
  output logic [XLEN-1:0]   fetch_pc_o,
  output logic [INST_W-1:0] fetch_inst_o
);

  // ========================================
  // program counter
  // ========================================
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_next;

  // request in flight, pairs the returned word with its address
  logic [XLEN-1:0] req_pc;
  logic            req_valid;

  assign pc_next = redirect_i ? redirect_pc_i : pc + PC_STEP;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc        <= RESET_PC;
      req_valid <= 1'b0;
    end else begin
      pc        <= pc_next;
      // a redirect kills the word issued this cycle
      req_valid <= ~redirect_i;
    end
  end

  always_ff @(posedge clk) begin
    req_pc <= pc;
  end

  // ========================================
  // memory side
  // ========================================
  assign imem_addr_o = pc;

  // word on imem_data_i belongs to last cycle's address
  assign fetch_valid_o = req_valid;
  assign fetch_pc_o    = req_pc;
  assign fetch_inst_o  = imem_data_i;

  // redirect targets come from execute, must stay word aligned
  assert property (@(posedge clk) disable iff (!rst_n_i)
    imem_addr_o[1:0] == 2'b00)
    else $error("fetch address not word aligned: %h", imem_addr_o);

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  fetch_valid_i,
  input  logic [XLEN-1:0]       fetch_pc_i,
  input  logic [INST_W-1:0]     fetch_inst_i,
  input  logic                  redirect_i,
  input  logic                  wb_we_i,
  input  logic [REG_ADDR_W-1:0] wb_rd_i,
  input  logic [XLEN-1:0]       wb_data_i,
  output logic                  ex_valid_o,
  output logic [XLEN-1:0]       ex_pc_o,
  output opcode_e               ex_op_o,
  output alu_op_e               ex_alu_op_o,
  output logic [XLEN-1:0]       ex_rs1_data_o,
  output logic [XLEN-1:0]       ex_rs2_data_o,
  output logic [XLEN-1:0]       ex_imm_o,
  output logic                  ex_use_imm_o,
  output logic [REG_ADDR_W-1:0] ex_rd_o,
  output logic                  ex_we_o,
  output logic                  ex_branch_ne_o
);

  // ========================================
  // instruction slot
  // ========================================
  logic              slot_valid;
  logic [INST_W-1:0] inst;

  // empty or flushed slot decodes as a nop
  assign slot_valid = fetch_valid_i & ~redirect_i;
  assign inst       = slot_valid ? fetch_inst_i : NOP_INST;

  opcode_e               opc;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [2:0]            funct3;
  logic                  funct7_5;

  assign opc      = opcode_e'(inst[6:0]);
  assign rd       = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1      = inst[19:15];
  assign rs2      = inst[24:20];
  assign funct7_5 = inst[30];

  // immediates
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ========================================
  // control decode
  // ========================================
  // sub only exists in the register form
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic f7_5,
                                         input logic is_reg);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = (is_reg && f7_5) ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = f7_5 ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  logic            dec_known;
  logic            dec_we;
  logic            dec_use_imm;
  alu_op_e         dec_alu_op;
  logic [XLEN-1:0] dec_imm;

  always_comb begin
    dec_known   = 1'b1;
    dec_we      = 1'b0;
    dec_use_imm = 1'b0;
    dec_alu_op  = ALU_ADD;
    dec_imm     = imm_i;
    case (opc)
      OPC_OP: begin
        dec_we     = 1'b1;
        dec_alu_op = alu_decode(funct3, funct7_5, 1'b1);
      end
      OPC_OP_IMM: begin
        dec_we      = 1'b1;
        dec_use_imm = 1'b1;
        dec_alu_op  = alu_decode(funct3, funct7_5, 1'b0);
      end
      OPC_LUI: begin
        dec_we      = 1'b1;
        dec_use_imm = 1'b1;
        dec_imm     = imm_u;
        dec_alu_op  = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        dec_imm    = imm_b;
        dec_alu_op = ALU_SUB;
        // only beq and bne are kept
        dec_known  = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
      end
      OPC_JAL: begin
        dec_we  = 1'b1;
        dec_imm = imm_j;
      end
      default: dec_known = 1'b0;
    endcase
  end

  // ========================================
  // register file
  // ========================================
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .waddr_i  (wb_rd_i),
    .we_i     (wb_we_i),
    .wdata_i  (wb_data_i),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  // ========================================
  // ID/EX register
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_valid_o <= 1'b0;
    end else begin
      // unknown encodings become bubbles
      ex_valid_o <= slot_valid & dec_known;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc_o        <= fetch_pc_i;
    ex_op_o        <= opc;
    ex_alu_op_o    <= dec_alu_op;
    ex_rs1_data_o  <= rs1_data;
    ex_rs2_data_o  <= rs2_data;
    ex_imm_o       <= dec_imm;
    ex_use_imm_o   <= dec_use_imm;
    ex_rd_o        <= dec_we ? rd : '0;
    ex_we_o        <= dec_we;
    ex_branch_ne_o <= (funct3 == F3_BNE);
  end

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  ex_valid_i,
  input  logic [XLEN-1:0]       ex_pc_i,
  input  opcode_e               ex_op_i,
  input  alu_op_e               ex_alu_op_i,
  input  logic [XLEN-1:0]       ex_rs1_data_i,
  input  logic [XLEN-1:0]       ex_rs2_data_i,
  input  logic [XLEN-1:0]       ex_imm_i,
  input  logic                  ex_use_imm_i,
  input  logic [REG_ADDR_W-1:0] ex_rd_i,
  input  logic                  ex_we_i,
  input  logic                  ex_branch_ne_i,
  output logic                  redirect_o,
  output logic [XLEN-1:0]       redirect_pc_o,
  output logic                  wb_we_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o,
  output logic                  retire_valid_o,
  output logic [XLEN-1:0]       retire_pc_o,
  output logic                  retire_we_o,
  output logic [REG_ADDR_W-1:0] retire_rd_o,
  output logic [XLEN-1:0]       retire_data_o
);

  // ========================================
  // alu
  // ========================================
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;
  logic            alu_equal;

  assign op_b = ex_use_imm_i ? ex_imm_i : ex_rs2_data_i;

  alu u_alu (
    .op_i     (ex_alu_op_i),
    .a_i      (ex_rs1_data_i),
    .b_i      (op_b),
    .result_o (alu_result),
    .equal_o  (alu_equal)
  );

  // ========================================
  // branch and jump
  // ========================================
  logic            is_jal;
  logic            taken;
  logic [XLEN-1:0] link_pc;

  assign is_jal  = (ex_op_i == OPC_JAL);
  // bne flips the sense of the compare
  assign taken   = (ex_op_i == OPC_BRANCH) && (alu_equal ^ ex_branch_ne_i);
  assign link_pc = ex_pc_i + PC_STEP;

  assign redirect_o    = ex_valid_i & (taken | is_jal);
  assign redirect_pc_o = ex_pc_i + ex_imm_i;

  // write-back into decode's register file
  assign wb_we_o   = ex_valid_i & ex_we_i;
  assign wb_rd_o   = ex_rd_i;
  assign wb_data_o = is_jal ? link_pc : alu_result;

  // ========================================
  // retire port
  // ========================================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc_o   <= ex_pc_i;
    retire_we_o   <= wb_we_o;
    retire_rd_o   <= wb_rd_o;
    retire_data_o <= wb_data_o;
  end

  // redirect needs a live instruction, and decode flushes the next slot
  assert property (@(posedge clk) disable iff (!rst_n_i)
    redirect_o |-> ex_valid_i ##1 !ex_valid_i)
    else $error("redirect without valid instruction or flush missed");

endmodule

// File: logic/core_top.sv
`timescale 1ns/1ps

module core_top import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [INST_W-1:0]     imem_data_i,
  output logic [XLEN-1:0]       imem_addr_o,
  output logic                  retire_valid_o,
  output logic [XLEN-1:0]       retire_pc_o,
  output logic                  retire_we_o,
  output logic [REG_ADDR_W-1:0] retire_rd_o,
  output logic [XLEN-1:0]       retire_data_o
);

  // fetch to decode
  logic              fetch_valid;
  logic [XLEN-1:0]   fetch_pc;
  logic [INST_W-1:0] fetch_inst;

  // decode to execute
  logic                  ex_valid;
  logic [XLEN-1:0]       ex_pc;
  opcode_e               ex_op;
  alu_op_e               ex_alu_op;
  logic [XLEN-1:0]       ex_rs1_data;
  logic [XLEN-1:0]       ex_rs2_data;
  logic [XLEN-1:0]       ex_imm;
  logic                  ex_use_imm;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic                  ex_we;
  logic                  ex_branch_ne;

  // execute back to the front
  logic                  redirect;
  logic [XLEN-1:0]       redirect_pc;
  logic                  wb_we;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  fetch_unit u_fetch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_data_i   (imem_data_i),
    .imem_addr_o   (imem_addr_o),
    .fetch_valid_o (fetch_valid),
    .fetch_pc_o    (fetch_pc),
    .fetch_inst_o  (fetch_inst)
  );

  decode_stage u_decode (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .fetch_valid_i  (fetch_valid),
    .fetch_pc_i     (fetch_pc),
    .fetch_inst_i   (fetch_inst),
    .redirect_i     (redirect),
    .wb_we_i        (wb_we),
    .wb_rd_i        (wb_rd),
    .wb_data_i      (wb_data),
    .ex_valid_o     (ex_valid),
    .ex_pc_o        (ex_pc),
    .ex_op_o        (ex_op),
    .ex_alu_op_o    (ex_alu_op),
    .ex_rs1_data_o  (ex_rs1_data),
    .ex_rs2_data_o  (ex_rs2_data),
    .ex_imm_o       (ex_imm),
    .ex_use_imm_o   (ex_use_imm),
    .ex_rd_o        (ex_rd),
    .ex_we_o        (ex_we),
    .ex_branch_ne_o (ex_branch_ne)
  );

  exec_stage u_exec (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ex_valid_i     (ex_valid),
    .ex_pc_i        (ex_pc),
    .ex_op_i        (ex_op),
    .ex_alu_op_i    (ex_alu_op),
    .ex_rs1_data_i  (ex_rs1_data),
    .ex_rs2_data_i  (ex_rs2_data),
    .ex_imm_i       (ex_imm),
    .ex_use_imm_i   (ex_use_imm),
    .ex_rd_i        (ex_rd),
    .ex_we_i        (ex_we),
    .ex_branch_ne_i (ex_branch_ne),
    .redirect_o     (redirect),
    .redirect_pc_o  (redirect_pc),
    .wb_we_o        (wb_we),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_we_o    (retire_we_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  // 20 ns period
  localparam int HALF_PERIOD = 10;

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #HALF_PERIOD;
    clk_o = ~clk_o;
  end

endmodule

// File: bench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// ========================================
// test programs
// ========================================
// every program starts at RESET_PC and ends in a jal to itself
task automatic build_programs();
  // dependent chain, each op reads the result just written
  start_test("alu_chain");
  place_writer(i_type(3'b000, 1, 0, 12), 1, 32'd12);                 // addi x1, x0, 12
  place_writer(i_type(3'b000, 2, 0, 5), 2, 32'd5);                   // addi x2, x0, 5
  place_writer(r_type(3'b000, 0, 3, 1, 2), 3, 32'd17);               // add  x3, x1, x2
  place_writer(r_type(3'b000, 1, 4, 3, 2), 4, 32'd12);               // sub  x4, x3, x2
  place_writer(r_type(3'b111, 0, 5, 4, 2), 5, 32'd4);                // and  x5, x4, x2
  place_writer(r_type(3'b110, 0, 6, 5, 1), 6, 32'd12);               // or   x6, x5, x1
  place_writer(r_type(3'b100, 0, 7, 6, 2), 7, 32'd9);                // xor  x7, x6, x2
  place_writer(r_type(3'b010, 0, 8, 2, 7), 8, 32'd1);                // slt  x8, x2, x7
  place_writer(r_type(3'b011, 0, 9, 0, 8), 9, 32'd1);                // sltu x9, x0, x8
  place_writer(r_type(3'b001, 0, 10, 7, 9), 10, 32'd18);             // sll  x10, x7, x9
  place_writer(r_type(3'b101, 0, 11, 10, 9), 11, 32'd9);             // srl  x11, x10, x9
  place_writer(r_type(3'b000, 1, 12, 0, 11), 12, 32'hFFFF_FFF7);     // sub  x12, x0, x11
  place_writer(r_type(3'b101, 1, 13, 12, 9), 13, 32'hFFFF_FFFB);     // sra  x13, x12, x9
  place_writer(jal_type(0, 0), 0, 32'd56);                           // jal  x0, 0

  // sign extension of I immediates, upper immediates
  start_test("imm_lui");
  place_writer(i_type(3'b000, 1, 0, -1), 1, 32'hFFFF_FFFF);          // addi x1, x0, -1
  place_writer(i_type(3'b000, 2, 1, -2048), 2, 32'hFFFF_F7FF);       // addi x2, x1, -2048
  place_writer(lui_type(3, 32'hABCDE), 3, 32'hABCD_E000);            // lui  x3, 0xabcde
  place_writer(i_type(3'b000, 4, 3, -16), 4, 32'hABCD_DFF0);         // addi x4, x3, -16
  place_writer(lui_type(5, 32'h80000), 5, 32'h8000_0000);            // lui  x5, 0x80000
  place_writer(i_type(3'b000, 6, 5, 2047), 6, 32'h8000_07FF);        // addi x6, x5, 2047
  place_writer(jal_type(0, 0), 0, 32'd28);                           // jal  x0, 0

  // beq and bne, both taken and not taken
  start_test("branches");
  place_writer(i_type(3'b000, 1, 0, 7), 1, 32'd7);                   // addi x1, x0, 7
  place_writer(i_type(3'b000, 2, 0, 7), 2, 32'd7);                   // addi x2, x0, 7
  place_branch(b_type(3'b000, 1, 2, 12));                            // beq  x1, x2, +12
  place_inst(i_type(3'b000, 3, 0, 1));                               // skipped
  place_inst(i_type(3'b000, 3, 0, 2));                               // skipped
  place_branch(b_type(3'b001, 1, 2, 8));                             // bne  x1, x2, +8
  place_writer(i_type(3'b000, 4, 0, 3), 4, 32'd3);                   // addi x4, x0, 3
  place_branch(b_type(3'b001, 4, 1, 8));                             // bne  x4, x1, +8
  place_inst(i_type(3'b000, 5, 0, 9));                               // skipped
  place_branch(b_type(3'b000, 4, 1, 8));                             // beq  x4, x1, +8
  place_writer(i_type(3'b000, 6, 4, 10), 6, 32'd13);                 // addi x6, x4, 10
  place_writer(jal_type(0, 0), 0, 32'd48);                           // jal  x0, 0

  // link values, writes to x0 and reads of x0
  start_test("jal_x0");
  place_writer(jal_type(1, 12), 1, 32'd4);                           // jal  x1, +12
  place_inst(i_type(3'b000, 2, 0, 1));                               // skipped
  place_inst(i_type(3'b000, 2, 0, 2));                               // skipped
  place_writer(i_type(3'b000, 0, 1, 5), 0, 32'd9);                   // addi x0, x1, 5
  place_writer(r_type(3'b000, 0, 3, 0, 1), 3, 32'd4);                // add  x3, x0, x1
  place_writer(jal_type(5, 8), 5, 32'd24);                           // jal  x5, +8
  place_inst(i_type(3'b000, 6, 0, 1));                               // skipped
  place_writer(r_type(3'b000, 0, 7, 5, 0), 7, 32'd24);               // add  x7, x5, x0
  place_writer(jal_type(0, 0), 0, 32'd36);                           // jal  x0, 0
endtask

`endif

// File: bench/tb_core.sv
`timescale 1ns/1ps

module tb_core import rv_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int MEM_AW       = 6;
  localparam int MEM_WORDS    = 1 << MEM_AW;

  logic                  clk;
  logic                  rst_n_i;
  logic [31:0]           imem_data_i;
  logic [XLEN-1:0]       imem_addr_o;
  logic                  retire_valid_o;
  logic [XLEN-1:0]       retire_pc_o;
  logic                  retire_we_o;
  logic [REG_ADDR_W-1:0] retire_rd_o;
  logic [XLEN-1:0]       retire_data_o;

  tb_clock u_clock (
    .clk_o (clk)
  );

  core_top i_dut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .imem_data_i    (imem_data_i),
    .imem_addr_o    (imem_addr_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_we_o    (retire_we_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  // ========================================
  // instruction memory, one cycle latency
  // ========================================
  logic [31:0] mem [MEM_WORDS];

  always @(posedge clk) begin
    imem_data_i <= mem[imem_addr_o[MEM_AW+1:2]];
  end

  // ========================================
  // test table
  // ========================================
  string       test_name[$];
  int          prog_start[$];
  int          prog_len[$];
  int          exp_start[$];
  int          exp_count[$];
  logic [31:0] prog_word[$];
  logic [31:0] exp_pc[$];
  logic [4:0]  exp_rd[$];
  logic        exp_we[$];
  logic [31:0] exp_data[$];

  int   cur_test     = 0;
  int   error_count  = 0;
  int   pass_tests   = 0;
  int   fail_tests   = 0;
  int   cycle_budget = 0;
  logic tables_ready = 1'b0;

  // encoders for the kept formats
  function automatic logic [31:0] r_type(input logic [2:0] f3, input int alt, input int rd,
                                         input int rs1, input int rs2);
    logic [31:0] d;
    logic [31:0] s1;
    logic [31:0] s2;
    d  = rd;
    s1 = rs1;
    s2 = rs2;
    return {1'b0, alt[0], 5'b0, s2[4:0], s1[4:0], f3, d[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd, input int rs1,
                                         input int imm);
    logic [31:0] d;
    logic [31:0] s1;
    logic [31:0] im;
    d  = rd;
    s1 = rs1;
    im = imm;
    return {im[11:0], s1[4:0], f3, d[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_type(input int rd, input logic [31:0] imm20);
    logic [31:0] d;
    d = rd;
    return {imm20[19:0], d[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] im;
    s1 = rs1;
    s2 = rs2;
    im = off;
    return {im[12], im[10:5], s2[4:0], s1[4:0], f3, im[4:1], im[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_type(input int rd, input int off);
    logic [31:0] d;
    logic [31:0] im;
    d  = rd;
    im = off;
    return {im[20], im[10:1], im[11], im[19:12], d[4:0], 7'b1101111};
  endfunction

  // unused words hold an unknown opcode that changes with the address
  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] a;
    a = idx;
    return {a[24:0], 7'b0000000};
  endfunction

  task automatic start_test(input string name);
    test_name.push_back(name);
    prog_start.push_back(prog_word.size());
    prog_len.push_back(0);
    exp_start.push_back(exp_pc.size());
    exp_count.push_back(0);
  endtask

  task automatic place_inst(input logic [31:0] word);
    int last;
    last = test_name.size() - 1;
    prog_word.push_back(word);
    prog_len[last] = prog_len[last] + 1;
  endtask

  task automatic place_expect(input logic [31:0] word, input int rd, input logic we,
                              input logic [31:0] data);
    int          last;
    logic [31:0] d;
    last = test_name.size() - 1;
    d    = rd;
    exp_pc.push_back(RESET_PC + 32'(prog_len[last] * 4));
    exp_rd.push_back(d[4:0]);
    exp_we.push_back(we);
    exp_data.push_back(data);
    exp_count[last] = exp_count[last] + 1;
    place_inst(word);
  endtask

  task automatic place_writer(input logic [31:0] word, input int rd, input logic [31:0] data);
    place_expect(word, rd, 1'b1, data);
  endtask

  task automatic place_branch(input logic [31:0] word);
    place_expect(word, 0, 1'b0, 32'd0);
  endtask

  `include "tb_programs.svh"

  // ========================================
  // checks
  // ========================================
  task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Mismatch at %0t ns: %s expected %h got %h", $time, sig, expected, actual);
    error_count++;
  endtask

  task automatic check_retire(input int e);
    if (retire_pc_o !== exp_pc[e]) begin
      report_mismatch("retire_pc_o", exp_pc[e], retire_pc_o);
    end
    if (retire_we_o !== exp_we[e]) begin
      report_mismatch("retire_we_o", {31'b0, exp_we[e]}, {31'b0, retire_we_o});
    end
    if (retire_rd_o !== exp_rd[e]) begin
      report_mismatch("retire_rd_o", {27'b0, exp_rd[e]}, {27'b0, retire_rd_o});
    end
    // branches write nothing, their data is not checked
    if (exp_we[e] && (retire_data_o !== exp_data[e])) begin
      report_mismatch("retire_data_o", exp_data[e], retire_data_o);
    end
  endtask

  task automatic load_program(input int t);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    for (int i = 0; i < prog_len[t]; i++) begin
      mem[i] = prog_word[prog_start[t] + i];
    end
  endtask

  task automatic run_test(input int t);
    int got;
    int errs_before;
    cur_test    = t;
    errs_before = error_count;
    @(posedge clk);
    rst_n_i <= 1'b0;
    @(negedge clk);
    load_program(t);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    // first cycle out of reset
    if (retire_valid_o !== 1'b0) begin
      report_mismatch("retire_valid_o", 32'd0, {31'b0, retire_valid_o});
    end
    if (imem_addr_o !== RESET_PC) begin
      report_mismatch("imem_addr_o", RESET_PC, imem_addr_o);
    end
    got = 0;
    while (got < exp_count[t]) begin
      if (retire_valid_o === 1'b1) begin
        check_retire(exp_start[t] + got);
        got++;
      end
      @(negedge clk);
    end
    if (error_count == errs_before) begin
      pass_tests++;
      $display("test %0d %s passed, %0d retirements", t, test_name[t], got);
    end else begin
      fail_tests++;
      $display("test %0d %s failed with %0d errors", t, test_name[t],
               error_count - errs_before);
    end
  endtask

  // ========================================
  // main sequence and watchdog
  // ========================================
  initial begin
    rst_n_i     <= 1'b0;
    imem_data_i <= '0;
    build_programs();
    for (int t = 0; t < test_name.size(); t++) begin
      cycle_budget += (RESET_CYCLES + 2) + 4 * exp_count[t] + 50;
    end
    tables_ready = 1'b1;
    for (int t = 0; t < test_name.size(); t++) begin
      run_test(t);
    end
    $display("tests passed %0d, failed %0d, failed checks %0d",
             pass_tests, fail_tests, error_count);
    if ((fail_tests == 0) && (error_count == 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    wait (tables_ready);
    repeat (cycle_budget) @(posedge clk);
    $display("timeout: test %0d %s stopped retiring before its expected count",
             cur_test, test_name[cur_test]);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: build.f
+incdir+bench
logic/rv_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/core_top.sv
bench/tb_clock.sv
bench/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --assert -j 0

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := bench/tb_programs.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)
